//--- sources.f
trace_pkg.sv
regs_pkg.sv
trace_shifter.sv
match_rule.sv
trigger_select.sv
trace_regs.sv
trace_trigger_top.sv
trace_trigger_checker.sv
tb_trace_trigger.sv

//--- run_sim.sh
#!/bin/sh
# build the trace trigger testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
  --top-module tb_trace_trigger -o sim_trace_trigger

# the simulator exits non-zero on failure, the search below decides
out=$(./obj_dir/sim_trace_trigger 2>&1) || true
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***"

//--- tb_trace_trigger.sv
/*
  trace trigger testbench
  table rows of rule setups with planted trace windows, checked cycle by
  cycle against a reference model of shifter, rules and trigger
*/
`timescale 1ns/1ps

module tb_trace_trigger;

  localparam int          num_rows    = 8;
  localparam int          watchdog_ns = num_rows * (80 + 40) * 20 * 2;
  localparam logic [63:0] all_ones    = '1;

  typedef struct {
    logic [1:0]  width;
    logic        toggle;
    logic [7:0]  enable;
    int          rule;        // rule programmed by this row
    logic [63:0] pattern;
    logic [63:0] mask;
    int          prefix;      // random cycles before the window
    int          plant_bits;  // planted window length, 0 for none
    logic        expect_hit;
  } row_t;

  logic       ext_clock;
  logic       resetn;
  logic [3:0] trace_data;
  logic       trcena;
  logic [7:0] reg_addr;
  logic [7:0] reg_wdata;
  logic       reg_write;
  logic       reg_read;
  logic [7:0] reg_rdata;
  logic       trig_out;

  row_t   rows [num_rows];
  integer seed;
  int     row_hits;  // trig_out level changes in the current row

  // reference model
  logic [63:0] m_buf;
  logic [63:0] m_buf_d;
  logic [63:0] m_last_buf;
  logic [63:0] m_pat [8];
  logic [63:0] m_mask [8];
  logic [7:0]  m_counts [8];
  logic [7:0]  m_hit;
  logic [7:0]  m_en;
  logic [7:0]  m_last_vec;
  logic [1:0]  m_width;
  logic        m_toggle;
  logic        m_trig;
  logic        m_valid;
  int          m_bits;

  trace_trigger_top i_trace_trigger_top (.*);

  initial begin
    ext_clock = 1'b0;
    forever #10 ext_clock = ~ext_clock;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // one clock edge of the model, later stages first
  function automatic void model_edge();
    int         n;
    logic [3:0] lane_sel;
    if (|m_hit) begin
      m_trig     = m_toggle ? ~m_trig : 1'b1;
      m_last_vec = m_hit;
      m_last_buf = m_buf_d;  // buffer the hits were computed from
    end else if (!m_toggle) begin
      m_trig = 1'b0;
    end
    m_buf_d = m_buf;
    for (int r = 0; r < 8; r++) begin
      m_hit[r] = m_valid && m_en[r] && ((m_buf & m_mask[r]) == (m_pat[r] & m_mask[r]));
      if (m_hit[r] && m_counts[r] != 8'hff)
        m_counts[r] = m_counts[r] + 8'd1;
    end
    n        = (m_width == 2'd0) ? 1 : (m_width == 2'd1) ? 2 : 4;
    lane_sel = (m_width == 2'd0) ? 4'h1 : (m_width == 2'd1) ? 4'h3 : 4'hf;
    if (trcena) begin
      m_buf  = (m_buf << n) | {60'd0, trace_data & lane_sel};
      m_bits = m_bits + n;
      if (m_bits >= 64) begin
        m_bits  = 64;
        m_valid = 1'b1;
      end
    end else begin
      m_bits  = 0;
      m_valid = 1'b0;
    end
    if (reg_write && reg_addr[7]) begin
      if (reg_addr[3])
        m_mask[reg_addr[6:4]][reg_addr[2:0]*8 +: 8] = reg_wdata;
      else
        m_pat[reg_addr[6:4]][reg_addr[2:0]*8 +: 8] = reg_wdata;
    end else if (reg_write && reg_addr[6:0] == 7'h00) begin
      m_en = reg_wdata;
    end else if (reg_write && reg_addr[6:0] == 7'h01) begin
      m_toggle = reg_wdata[0];
      m_width  = reg_wdata[2:1];
    end
  endfunction

  function automatic logic [7:0] model_read(input logic [7:0] addr);
    logic [7:0] value;
    value = 8'h00;  // unmapped and rule space
    if (!addr[7]) begin
      if (addr[6:0] == 7'h00)
        value = m_en;
      else if (addr[6:0] == 7'h01)
        value = {5'b0, m_width, m_toggle};
      else if (addr[6:0] == 7'h02)
        value = m_last_vec;
      else if (addr[6:3] == 4'h1)
        value = m_last_buf[addr[2:0]*8 +: 8];
      else if (addr[6:3] == 4'h2)
        value = m_counts[addr[2:0]];
    end
    return value;
  endfunction

  task automatic tick();
    logic trig_before;
    trig_before = trig_out;
    @(posedge ext_clock);
    model_edge();
    @(negedge ext_clock);
    check_value("trig_out", 64'(trig_out), 64'(m_trig));
    if (trig_out != trig_before)
      row_hits++;  // pulse edge or toggle
  endtask

  task automatic reg_wr(input logic [7:0] addr, input logic [7:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_write = 1'b1;
    tick();
    reg_write = 1'b0;
  endtask

  task automatic reg_rd(input logic [7:0] addr, input string name);
    logic [7:0] expected;
    expected = model_read(addr);
    reg_addr = addr;
    reg_read = 1'b1;
    tick();
    reg_read = 1'b0;
    check_value(name, 64'(reg_rdata), 64'(expected));
  endtask

  task automatic trace_step(input logic [3:0] data);
    trace_data = data;
    trcena     = 1'b1;
    tick();
  endtask

  task automatic run_row(input row_t row);
    int          k;
    int          b;
    int          lanes;
    logic [3:0]  d;
    logic [63:0] window;
    reg_wr({1'b0, regs_pkg::addr_control}, {5'b0, row.width, row.toggle});
    reg_wr({1'b0, regs_pkg::addr_enable}, row.enable);
    for (k = 0; k < 8; k++) begin
      reg_wr({1'b1, 3'(row.rule), 1'b0, 3'(k)}, row.pattern[k*8 +: 8]);
      reg_wr({1'b1, 3'(row.rule), 1'b1, 3'(k)}, row.mask[k*8 +: 8]);
    end
    reg_rd({1'b0, regs_pkg::addr_enable}, "enable");
    reg_rd({1'b0, regs_pkg::addr_control}, "control");
    lanes    = (row.width == 2'd0) ? 1 : (row.width == 2'd1) ? 2 : 4;
    window   = (row.pattern & row.mask) | ({$random(seed), $random(seed)} & ~row.mask);
    row_hits = 0;
    for (k = 0; k < row.prefix; k++)
      trace_step(4'($random(seed)));
    for (k = row.plant_bits / lanes - 1; k >= 0; k--) begin
      d = 4'($random(seed));  // unused lanes stay random
      for (b = 0; b < lanes; b++)
        d[b] = window[k*lanes + b];
      trace_step(d);
    end
    for (k = 0; k < 4; k++)
      trace_step(4'($random(seed)));
    trcena = 1'b0;
    check_value("row_hit", 64'(row_hits != 0), 64'(row.expect_hit));
    reg_rd({1'b0, regs_pkg::addr_hit_vector}, "hit_vector");
    for (k = 0; k < 8; k++)
      reg_rd({1'b0, regs_pkg::addr_hit_buffer + 7'(k)}, $sformatf("hit_buffer[%0d]", k));
    for (k = 0; k < 8; k++)
      reg_rd({1'b0, regs_pkg::addr_count + 7'(k)}, $sformatf("hit_count[%0d]", k));
  endtask

  task automatic fill_table();
    rows[0] = '{2'd2, 1'b0, 8'h01, 0, 64'h0123_4567_89ab_cdef, all_ones, 6, 64, 1'b1};
    rows[1] = '{2'd2, 1'b0, 8'h03, 1, 64'hdead_beef_0bad_f00d,
                64'hffff_0000_ffff_f0f0, 5, 64, 1'b1};  // don't-care bits
    rows[2] = '{2'd2, 1'b0, 8'h03, 2, 64'h5a5a_1234_a5a5_8765, all_ones, 3, 64, 1'b0};
    rows[3] = '{2'd0, 1'b0, 8'h04, 2, 64'h5a5a_1234_a5a5_8765, all_ones, 4, 64, 1'b1};
    rows[4] = '{2'd1, 1'b0, 8'h0c, 3, 64'hc3c3_0f0f_7e7e_1001, all_ones, 2, 64, 1'b1};
    rows[5] = '{2'd1, 1'b0, 8'h0c, 3, 64'hc3c3_0f0f_7e7e_1001, all_ones, 40, 0, 1'b0};
    rows[6] = '{2'd2, 1'b1, 8'h01, 0, 64'h0123_4567_89ab_cdef, all_ones, 4, 64, 1'b1};
    rows[7] = '{2'd3, 1'b0, 8'h10, 4, 64'h0000_0000_0000_beef,
                64'h0000_0000_0000_ffff, 0, 16, 1'b0};  // window shorter than 64 bits
  endtask

  initial begin
    seed       = 32'h9d3a_c71b;
    resetn     = 1'b0;
    trace_data = 4'h0;
    trcena     = 1'b0;
    reg_addr   = 8'h00;
    reg_wdata  = 8'h00;
    reg_write  = 1'b0;
    reg_read   = 1'b0;
    m_buf      = '0;
    m_buf_d    = '0;
    m_last_buf = '0;
    m_hit      = '0;
    m_en       = '0;
    m_last_vec = '0;
    m_width    = '0;
    m_toggle   = 1'b0;
    m_trig     = 1'b0;
    m_valid    = 1'b0;
    m_bits     = 0;
    for (int r = 0; r < 8; r++) begin
      m_pat[r]    = '0;
      m_mask[r]   = '0;
      m_counts[r] = '0;
    end
    fill_table();
    repeat (3) @(posedge ext_clock);
    @(negedge ext_clock);
    resetn = 1'b1;
    reg_rd({1'b0, regs_pkg::addr_enable}, "enable");
    reg_rd({1'b0, regs_pkg::addr_control}, "control");
    reg_wr({1'b0, regs_pkg::addr_control}, 8'h05);
    reg_rd({1'b0, regs_pkg::addr_control}, "control");
    reg_wr({1'b0, regs_pkg::addr_enable}, 8'h5a);
    reg_rd({1'b0, regs_pkg::addr_enable}, "enable");
    reg_wr({1'b0, regs_pkg::addr_enable}, 8'h00);
    reg_rd(8'h03, "unmapped 0x03");
    reg_rd(8'h1f, "unmapped 0x1f");
    reg_rd(8'h85, "rule space 0x85");  // pattern bytes are write only
    for (int r = 0; r < num_rows; r++)
      run_row(rows[r]);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

//--- trace_trigger_checker.sv
/*
  trace trigger checker
  concurrent assertions on the trigger output and the register bus
*/
`timescale 1ns/1ps

module trace_trigger_checker (
  input logic                            ext_clock,
  input logic                            resetn,
  input logic                            trig_out,
  input logic                            toggle_mode,
  input logic [trace_pkg::num_rules-1:0] hit_vector,
  input logic                            reg_read,
  input logic                            reg_write
);

  trig_known: assert property (@(posedge ext_clock) disable iff (!resetn)
    !$isunknown(trig_out))
    else $error("trig_out is unknown");

  // mode and hits as seen by the edge that set trig_out
  pulse_has_hit: assert property (@(posedge ext_clock) disable iff (!resetn)
    (trig_out && !$past(toggle_mode)) |-> $past(|hit_vector))
    else $error("trig_out pulse without a hit in the prior cycle");

  bus_exclusive: assert property (@(posedge ext_clock) disable iff (!resetn)
    !(reg_read && reg_write))
    else $error("reg_read and reg_write high together");

endmodule

bind trace_trigger_top trace_trigger_checker i_trace_trigger_checker (
  .ext_clock   (ext_clock),
  .resetn      (resetn),
  .trig_out    (trig_out),
  .toggle_mode (toggle_mode),
  .hit_vector  (hit_vector),
  .reg_read    (reg_read),
  .reg_write   (reg_write)
);

//--- trace_trigger_top.sv
/*
  trace trigger top
  trace shifter feeding eight match rules, the trigger selector and the
  register file on one clock
*/
`timescale 1ns/1ps

module trace_trigger_top (
  input  logic                               ext_clock,
  input  logic                               resetn,
  input  logic [trace_pkg::lanes_max-1:0]    trace_data,
  input  logic                               trcena,
  input  logic [regs_pkg::reg_addr_bits-1:0] reg_addr,
  input  logic [regs_pkg::reg_data_bits-1:0] reg_wdata,
  input  logic                               reg_write,
  input  logic                               reg_read,
  output logic [regs_pkg::reg_data_bits-1:0] reg_rdata,
  output logic                               trig_out
);

  logic [trace_pkg::buffer_bits-1:0]     trace_buffer;
  logic                                  buffer_valid;
  logic [trace_pkg::width_code_bits-1:0] width_code;
  logic                                  toggle_mode;

  // per-rule configuration and results
  logic [trace_pkg::num_rules-1:0][trace_pkg::buffer_bits-1:0] rule_pattern;
  logic [trace_pkg::num_rules-1:0][trace_pkg::buffer_bits-1:0] rule_mask;
  logic [trace_pkg::num_rules-1:0]                             rule_enable;
  logic [trace_pkg::num_rules-1:0]                             hit_vector;
  logic [trace_pkg::num_rules-1:0][trace_pkg::count_bits-1:0]  hit_counts;

  // trigger snapshot
  logic [trace_pkg::num_rules-1:0]   last_hit_vector;
  logic [trace_pkg::buffer_bits-1:0] last_hit_buffer;

  trace_shifter i_trace_shifter (
    .ext_clock    (ext_clock),
    .resetn       (resetn),
    .trace_data   (trace_data),
    .trcena       (trcena),
    .width_code   (width_code),
    .trace_buffer (trace_buffer),
    .buffer_valid (buffer_valid)
  );

  for (genvar i = 0; i < trace_pkg::num_rules; i++) begin : g_rule
    match_rule i_match_rule (
      .ext_clock    (ext_clock),
      .resetn       (resetn),
      .trace_buffer (trace_buffer),
      .buffer_valid (buffer_valid),
      .rule_enable  (rule_enable[i]),
      .rule_pattern (rule_pattern[i]),
      .rule_mask    (rule_mask[i]),
      .hit          (hit_vector[i]),
      .hit_count    (hit_counts[i])
    );
  end

  trigger_select i_trigger_select (
    .ext_clock       (ext_clock),
    .resetn          (resetn),
    .hit_vector      (hit_vector),
    .trace_buffer    (trace_buffer),
    .toggle_mode     (toggle_mode),
    .trig_out        (trig_out),
    .last_hit_vector (last_hit_vector),
    .last_hit_buffer (last_hit_buffer)
  );

  trace_regs i_trace_regs (
    .ext_clock       (ext_clock),
    .resetn          (resetn),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .reg_write       (reg_write),
    .reg_read        (reg_read),
    .reg_rdata       (reg_rdata),
    .rule_pattern    (rule_pattern),
    .rule_mask       (rule_mask),
    .rule_enable     (rule_enable),
    .width_code      (width_code),
    .toggle_mode     (toggle_mode),
    .hit_counts      (hit_counts),
    .last_hit_vector (last_hit_vector),
    .last_hit_buffer (last_hit_buffer)
  );

endmodule

//--- trace_regs.sv
/*
  trace trigger registers
  byte-wide register file holding patterns, masks, enables and control,
  with a registered read mux for status and hit counts
*/
`timescale 1ns/1ps

module trace_regs (
  input  logic                                  ext_clock,
  input  logic                                  resetn,
  input  logic [regs_pkg::reg_addr_bits-1:0]    reg_addr,
  input  logic [regs_pkg::reg_data_bits-1:0]    reg_wdata,
  input  logic                                  reg_write,
  input  logic                                  reg_read,
  output logic [regs_pkg::reg_data_bits-1:0]    reg_rdata,
  output logic [trace_pkg::num_rules-1:0][trace_pkg::buffer_bits-1:0] rule_pattern,
  output logic [trace_pkg::num_rules-1:0][trace_pkg::buffer_bits-1:0] rule_mask,
  output logic [trace_pkg::num_rules-1:0]       rule_enable,
  output logic [trace_pkg::width_code_bits-1:0] width_code,
  output logic                                  toggle_mode,
  input  logic [trace_pkg::num_rules-1:0][trace_pkg::count_bits-1:0] hit_counts,
  input  logic [trace_pkg::num_rules-1:0]       last_hit_vector,
  input  logic [trace_pkg::buffer_bits-1:0]     last_hit_buffer
);

  regs_pkg::reg_addr_u                addr_u;
  logic [regs_pkg::reg_data_bits-1:0] read_mux;
  logic                               ctrl_write;
  logic                               rule_write;

  assign addr_u     = reg_addr;
  assign rule_write = reg_write && addr_u.rule.rule_space;
  assign ctrl_write = reg_write && !addr_u.ctrl.rule_space;

  // pattern and mask bytes, write only
  always_ff @(posedge ext_clock) begin
    if (rule_write) begin
      if (addr_u.rule.field == regs_pkg::field_mask) begin
        rule_mask[addr_u.rule.rule_idx][addr_u.rule.byte_idx*regs_pkg::reg_data_bits
                                        +: regs_pkg::reg_data_bits] <= reg_wdata;
      end else begin
        rule_pattern[addr_u.rule.rule_idx][addr_u.rule.byte_idx*regs_pkg::reg_data_bits
                                           +: regs_pkg::reg_data_bits] <= reg_wdata;
      end
    end
  end

  // enable vector and control
  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      rule_enable <= '0;
      toggle_mode <= 1'b0;
      width_code  <= '0;
    end else if (ctrl_write) begin
      if (addr_u.ctrl.offset == regs_pkg::addr_enable) begin
        rule_enable <= reg_wdata;
      end else if (addr_u.ctrl.offset == regs_pkg::addr_control) begin
        toggle_mode <= reg_wdata[regs_pkg::ctrl_toggle_bit];
        width_code  <= reg_wdata[regs_pkg::ctrl_width_lsb +: trace_pkg::width_code_bits];
      end
    end
  end

  // read mux, anything unmapped reads 0
  always_comb begin
    read_mux = '0;
    if (!addr_u.ctrl.rule_space) begin
      if (addr_u.ctrl.offset == regs_pkg::addr_enable) begin
        read_mux = rule_enable;
      end else if (addr_u.ctrl.offset == regs_pkg::addr_control) begin
        read_mux[regs_pkg::ctrl_toggle_bit] = toggle_mode;
        read_mux[regs_pkg::ctrl_width_lsb +: trace_pkg::width_code_bits] = width_code;
      end else if (addr_u.ctrl.offset == regs_pkg::addr_hit_vector) begin
        read_mux = last_hit_vector;
      end else if (addr_u.ctrl.offset[6:3] == regs_pkg::addr_hit_buffer[6:3]) begin
        read_mux = last_hit_buffer[addr_u.ctrl.offset[2:0]*regs_pkg::reg_data_bits
                                   +: regs_pkg::reg_data_bits];  // byte 0 is lsb
      end else if (addr_u.ctrl.offset[6:3] == regs_pkg::addr_count[6:3]) begin
        read_mux = hit_counts[addr_u.ctrl.offset[2:0]];
      end
    end
  end

  // held until the next read
  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      reg_rdata <= '0;
    end else if (reg_read) begin
      reg_rdata <= read_mux;
    end
  end

endmodule

//--- trigger_select.sv
/*
  trigger select
  ORs the rule hits into the trigger output, pulsed or toggled, and latches
  the hit vector with the buffer the hits were computed from
*/
`timescale 1ns/1ps

module trigger_select (
  input  logic                              ext_clock,
  input  logic                              resetn,
  input  logic [trace_pkg::num_rules-1:0]   hit_vector,
  input  logic [trace_pkg::buffer_bits-1:0] trace_buffer,
  input  logic                              toggle_mode,
  output logic                              trig_out,
  output logic [trace_pkg::num_rules-1:0]   last_hit_vector,
  output logic [trace_pkg::buffer_bits-1:0] last_hit_buffer
);

  logic                              any_hit;
  logic [trace_pkg::buffer_bits-1:0] buffer_d;  // buffer seen by the rules

  assign any_hit = |hit_vector;

  // hits lag the buffer by one edge, so keep the matching copy
  always_ff @(posedge ext_clock) begin
    buffer_d <= trace_buffer;
  end

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      trig_out <= 1'b0;
    end else if (toggle_mode) begin
      if (any_hit) begin
        trig_out <= ~trig_out;  // one flip per hit cycle
      end
    end else begin
      trig_out <= any_hit;      // pulse follows the hit cycle
    end
  end

  // snapshot for readback
  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      last_hit_vector <= '0;
      last_hit_buffer <= '0;
    end else if (any_hit) begin
      last_hit_vector <= hit_vector;
      last_hit_buffer <= buffer_d;
    end
  end

endmodule

//--- match_rule.sv
/*
  match rule
  compares the masked history buffer with a programmed pattern, registers
  the hit and keeps a saturating count of hits
*/
`timescale 1ns/1ps

module match_rule (
  input  logic                               ext_clock,
  input  logic                               resetn,
  input  logic [trace_pkg::buffer_bits-1:0]  trace_buffer,
  input  logic                               buffer_valid,
  input  logic                               rule_enable,
  input  logic [trace_pkg::buffer_bits-1:0]  rule_pattern,
  input  logic [trace_pkg::buffer_bits-1:0]  rule_mask,
  output logic                               hit,
  output logic [trace_pkg::count_bits-1:0]   hit_count
);

  logic masked_equal;
  logic match_now;

  // mask bit 0 means don't care
  assign masked_equal = ((trace_buffer & rule_mask) == (rule_pattern & rule_mask));

  // only a full window on an enabled rule counts
  assign match_now = buffer_valid && rule_enable && masked_equal;

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      hit <= 1'b0;
    end else begin
      hit <= match_now;  // one cycle after the sampled buffer
    end
  end

  // counts on the same edge that raises hit
  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      hit_count <= '0;
    end else if (match_now && (hit_count != '1)) begin
      hit_count <= hit_count + 1'b1;  // sticks at all ones
    end
  end

endmodule

//--- trace_shifter.sv
/*
  trace shifter
  shifts one, two or four trace lanes into the 64-bit history buffer and
  flags the buffer valid once a full window has arrived since trcena rose
*/
`timescale 1ns/1ps

module trace_shifter (
  input  logic                                  ext_clock,
  input  logic                                  resetn,
  input  logic [trace_pkg::lanes_max-1:0]       trace_data,
  input  logic                                  trcena,
  input  logic [trace_pkg::width_code_bits-1:0] width_code,
  output logic [trace_pkg::buffer_bits-1:0]     trace_buffer,
  output logic                                  buffer_valid
);

  // counts 0..buffer_bits
  typedef logic [$clog2(trace_pkg::buffer_bits):0] count_t;

  count_t                            bit_count;   // bits received, saturating
  count_t                            lane_count;  // bits per cycle
  count_t                            count_sum;
  logic [trace_pkg::buffer_bits-1:0] shifted;

  // new bits enter at the low end, older bits move up
  always_comb begin
    case (width_code)
      2'd0: begin
        lane_count = count_t'(1);
        shifted    = {trace_buffer[trace_pkg::buffer_bits-2:0], trace_data[0]};
      end
      2'd1: begin
        lane_count = count_t'(2);
        shifted    = {trace_buffer[trace_pkg::buffer_bits-3:0], trace_data[1:0]};
      end
      default: begin  // codes 2 and 3
        lane_count = count_t'(trace_pkg::lanes_max);
        shifted    = {trace_buffer[trace_pkg::buffer_bits-trace_pkg::lanes_max-1:0],
                      trace_data};
      end
    endcase
  end

  assign count_sum = bit_count + lane_count;  // cannot wrap, max 64 + 4

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      trace_buffer <= '0;
      bit_count    <= '0;
      buffer_valid <= 1'b0;
    end else if (trcena) begin
      trace_buffer <= shifted;
      if (count_sum >= count_t'(trace_pkg::buffer_bits)) begin
        bit_count    <= count_t'(trace_pkg::buffer_bits);  // saturate
        buffer_valid <= 1'b1;
      end else begin
        bit_count    <= count_sum;
      end
    end else begin
      bit_count    <= '0;    // restart the window count
      buffer_valid <= 1'b0;
    end
  end

endmodule

//--- regs_pkg.sv
/*
  register bus definitions
  bus widths, control-space offsets and the two views of the bus address
*/
package regs_pkg;

  localparam int reg_addr_bits = 8;  // byte-wide address
  localparam int reg_data_bits = 8;  // byte-wide data

  // rule view, bit 7 set
  typedef struct packed {
    logic       rule_space;  // 1 selects pattern/mask storage
    logic [2:0] rule_idx;    // which rule
    logic       field;       // 0 pattern, 1 mask
    logic [2:0] byte_idx;    // byte 0 is the least significant
  } rule_view_t;

  // control view, bit 7 clear
  typedef struct packed {
    logic                     rule_space;
    logic [reg_addr_bits-2:0] offset;
  } ctrl_view_t;

  // one address word, decoded either way
  typedef union packed {
    rule_view_t rule;
    ctrl_view_t ctrl;
  } reg_addr_u;

  localparam logic field_mask = 1'b1;  // rule-view field code for the mask

  // control-space offsets
  localparam logic [reg_addr_bits-2:0] addr_enable     = 7'h00;  // rw
  localparam logic [reg_addr_bits-2:0] addr_control    = 7'h01;  // rw
  localparam logic [reg_addr_bits-2:0] addr_hit_vector = 7'h02;  // ro
  localparam logic [reg_addr_bits-2:0] addr_hit_buffer = 7'h08;  // ro, 8 bytes
  localparam logic [reg_addr_bits-2:0] addr_count      = 7'h10;  // ro, one per rule

  // bit positions in the control register
  localparam int ctrl_toggle_bit = 0;  // toggle mode
  localparam int ctrl_width_lsb  = 1;  // width code, 2 bits

endpackage

//--- trace_pkg.sv
/*
  trace trigger constants
  sizes of the history buffer, the rule bank, the trace lanes and the hit
  counters, plus the lane-select code width
*/
package trace_pkg;

  // history buffer
  localparam int buffer_bits = 64;  // bits of trace history compared per rule

  // rule bank
  localparam int num_rules = 8;     // identical match rules
  localparam int count_bits = 8;    // saturating hit counter width

  // trace port
  localparam int lanes_max = 4;     // physical TRACEDATA lanes

  // lane-select code
  //   0 -> one lane (bit 0)
  //   1 -> two lanes (bits 1..0)
  //   2 -> four lanes, 3 behaves the same
  localparam int width_code_bits = 2;

endpackage
